// File: Bender.yml
package:
  name: sample_buffer

sources:
  - sample_buffer_pkg.sv
  - capture_fsm.sv
  - sample_counter.sv
  - bank_memory.sv
  - readout_sequencer.sv
  - sample_buffer.sv
  - target: test
    files:
      - sample_buffer_assertions.sv
      - sample_buffer_tb.sv

// File: bank_memory.sv
`default_nettype none

module bank_memory #(
  parameter int CHANNELS = 2,
  parameter int DATA_WIDTH = 16,
  parameter int BUFFER_DEPTH = 64,
  parameter int READ_LATENCY = 3,
  localparam int AW = $clog2(BUFFER_DEPTH),
  localparam int BANK_W = (CHANNELS > 1) ? $clog2(CHANNELS) : 1
) (
  input  wire                                  ps_clk,
  input  wire [CHANNELS*DATA_WIDTH-1:0]        adc_data_i,
  input  wire [sample_buffer_pkg::MODE_W-1:0]  banking_mode_i,
  input  wire [CHANNELS-1:0]                   write_en_i,
  input  wire [CHANNELS*AW-1:0]                write_addr_i,
  input  wire [BANK_W-1:0]                     read_bank_i,
  input  wire [AW-1:0]                         read_addr_i,
  output logic [DATA_WIDTH-1:0]                read_data_o
);

  logic [DATA_WIDTH-1:0] wr_data [CHANNELS];
  logic [DATA_WIDTH-1:0] mem [CHANNELS][BUFFER_DEPTH];
  // read pipeline, stage 0 is the ram output register
  logic [DATA_WIDTH-1:0] rd_pipe [READ_LATENCY];

  // steer samples into banks
  always_comb begin
    for (int b = 0; b < CHANNELS; b++) begin
      if (banking_mode_i == '0) begin
        wr_data[b] = adc_data_i[b*DATA_WIDTH +: DATA_WIDTH];
      end else begin
        // chained mode, channel 0 feeds every bank
        wr_data[b] = adc_data_i[0 +: DATA_WIDTH];
      end
    end
  end

  // one write port per bank, all may fire in the same cycle
  always_ff @(posedge ps_clk) begin
    for (int b = 0; b < CHANNELS; b++) begin
      if (write_en_i[b]) begin
        mem[b][write_addr_i[b*AW +: AW]] <= wr_data[b];
      end
    end
  end

  // the read chain always runs
  // the sequencer tags which outputs are real words
  always_ff @(posedge ps_clk) begin
    rd_pipe[0] <= mem[read_bank_i][read_addr_i];
    for (int i = 1; i < READ_LATENCY; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign read_data_o = rd_pipe[READ_LATENCY-1];

endmodule

`default_nettype wire

// File: capture_fsm.sv
`default_nettype none

module capture_fsm (
  input  wire                                      ps_clk,
  input  wire                                      rst_n_i,
  input  wire                                      capture_arm_i,
  input  wire [sample_buffer_pkg::MODE_W-1:0]      banking_mode_i,
  input  wire                                      capture_hw_start_i,
  input  wire                                      capture_hw_stop_i,
  input  wire                                      capture_sw_reset_i,
  input  wire                                      readout_sw_reset_i,
  input  wire                                      readout_start_i,
  input  wire                                      banks_full_i,
  input  wire                                      readout_done_i,
  output sample_buffer_pkg::buffer_state_e         state_o,
  output logic [sample_buffer_pkg::MODE_W-1:0]     banking_mode_o,
  output logic                                     depth_report_o
);

  sample_buffer_pkg::buffer_state_e state_d;

  // next state and the depth report marker
  // depth_report_o is high in the last capture cycle, so the depth word
  // registered on that edge shows up in the first hold cycle
  always_comb begin
    state_d = state_o;
    depth_report_o = 1'b0;
    case (state_o)
      sample_buffer_pkg::IDLE: begin
        if (capture_arm_i) begin
          state_d = sample_buffer_pkg::ARMED;
        end
      end
      sample_buffer_pkg::ARMED: begin
        // capture reset beats the start trigger
        if (capture_sw_reset_i) begin
          state_d = sample_buffer_pkg::IDLE;
        end else if (capture_hw_start_i) begin
          state_d = sample_buffer_pkg::CAPTURE;
        end
      end
      sample_buffer_pkg::CAPTURE: begin
        // an aborted capture never reports a depth
        if (capture_sw_reset_i) begin
          state_d = sample_buffer_pkg::IDLE;
        end else if (capture_hw_stop_i || banks_full_i) begin
          state_d = sample_buffer_pkg::HOLD;
          depth_report_o = 1'b1;
        end
      end
      sample_buffer_pkg::HOLD: begin
        if (capture_sw_reset_i) begin
          state_d = sample_buffer_pkg::IDLE;
        end else if (readout_start_i) begin
          state_d = sample_buffer_pkg::READOUT;
        end
      end
      sample_buffer_pkg::READOUT: begin
        // readout reset keeps the data, so go back to hold
        // capture reset has no effect here
        if (readout_sw_reset_i) begin
          state_d = sample_buffer_pkg::HOLD;
        end else if (readout_done_i) begin
          state_d = sample_buffer_pkg::IDLE;
        end
      end
      default: begin
        state_d = sample_buffer_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge ps_clk) begin
    if (!rst_n_i) begin
      state_o <= sample_buffer_pkg::IDLE;
      banking_mode_o <= '0;
    end else begin
      state_o <= state_d;
      // mode is only taken when the arm pulse is accepted
      if ((state_o == sample_buffer_pkg::IDLE) && capture_arm_i) begin
        banking_mode_o <= banking_mode_i;
      end
    end
  end

endmodule

`default_nettype wire

// File: readout_sequencer.sv
`default_nettype none

module readout_sequencer #(
  parameter int CHANNELS = 2,
  parameter int BUFFER_DEPTH = 64,
  parameter int READ_LATENCY = 3,
  localparam int AW = $clog2(BUFFER_DEPTH),
  localparam int DW = AW + 1,
  localparam int BANK_W = (CHANNELS > 1) ? $clog2(CHANNELS) : 1
) (
  input  wire                               ps_clk,
  input  wire                               rst_n_i,
  input  sample_buffer_pkg::buffer_state_e  state_i,
  input  wire [CHANNELS*DW-1:0]             write_depth_i,
  output logic [BANK_W-1:0]                 read_bank_o,
  output logic [AW-1:0]                     read_addr_o,
  output logic                              readout_valid_o,
  output logic                              readout_last_o,
  output logic                              readout_done_o
);

  // extra bit so the bank pointer can step past the last bank
  logic [BANK_W:0] bank_q;
  logic [AW-1:0] addr_q;
  logic [DW-1:0] cur_depth;
  logic found;
  logic more_after;
  logic bank_end;
  logic issue;
  logic issue_last;
  logic in_readout;
  // valid and last tags, matched to the memory read chain
  logic [READ_LATENCY-1:0] valid_sr;
  logic [READ_LATENCY-1:0] last_sr;

  assign in_readout = (state_i == sample_buffer_pkg::READOUT);

  // pick the first non-empty bank at or after the pointer
  // scan from the top so the lowest match wins
  always_comb begin
    found = 1'b0;
    more_after = 1'b0;
    read_bank_o = '0;
    cur_depth = '0;
    for (int b = CHANNELS - 1; b >= 0; b--) begin
      if ((b >= bank_q) && (write_depth_i[b*DW +: DW] != '0)) begin
        // a higher non-empty bank was already seen
        more_after = found;
        found = 1'b1;
        read_bank_o = BANK_W'(b);
        cur_depth = write_depth_i[b*DW +: DW];
      end
    end
  end

  assign read_addr_o = addr_q;
  assign bank_end = (DW'(addr_q) == (cur_depth - DW'(1)));
  assign issue = in_readout && found;
  assign issue_last = bank_end && !more_after;

  always_ff @(posedge ps_clk) begin
    if (!rst_n_i) begin
      bank_q <= '0;
      addr_q <= '0;
      valid_sr <= '0;
      last_sr <= '0;
    end else if (!in_readout) begin
      // a readout reset or completion drops the pointers and all tags
      bank_q <= '0;
      addr_q <= '0;
      valid_sr <= '0;
      last_sr <= '0;
    end else begin
      valid_sr <= (valid_sr << 1) | READ_LATENCY'(issue);
      last_sr <= (last_sr << 1) | READ_LATENCY'(issue && issue_last);
      if (issue) begin
        if (bank_end) begin
          addr_q <= '0;
          bank_q <= {1'b0, read_bank_o} + 1'b1;
        end else begin
          addr_q <= addr_q + 1'b1;
        end
      end
    end
  end

  // state gating kills in-flight tags in the cycle after a readout reset
  assign readout_valid_o = valid_sr[READ_LATENCY-1] && in_readout;
  assign readout_last_o = last_sr[READ_LATENCY-1] && in_readout;

  // finished on the last word, or at once when nothing was stored
  assign readout_done_o = readout_last_o || (in_readout && !found && (valid_sr == '0));

endmodule

`default_nettype wire

// File: sample_buffer.f
sample_buffer_pkg.sv
capture_fsm.sv
sample_counter.sv
bank_memory.sv
readout_sequencer.sv
sample_buffer.sv
sample_buffer_assertions.sv
sample_buffer_tb.sv

// File: sample_buffer.sv
`default_nettype none

module sample_buffer #(
  parameter int CHANNELS = sample_buffer_pkg::DEFAULT_CHANNELS,
  parameter int DATA_WIDTH = sample_buffer_pkg::DEFAULT_DATA_WIDTH,
  parameter int BUFFER_DEPTH = sample_buffer_pkg::DEFAULT_BUFFER_DEPTH,
  parameter int READ_LATENCY = sample_buffer_pkg::DEFAULT_READ_LATENCY,
  localparam int AW = $clog2(BUFFER_DEPTH),
  localparam int DW = AW + 1,
  localparam int BANK_W = (CHANNELS > 1) ? $clog2(CHANNELS) : 1
) (
  input  wire                                  ps_clk,
  input  wire                                  rst_n_i,
  input  wire [CHANNELS*DATA_WIDTH-1:0]        adc_data_i,
  input  wire                                  adc_valid_i,
  input  wire                                  capture_arm_i,
  input  wire [sample_buffer_pkg::MODE_W-1:0]  banking_mode_i,
  input  wire                                  capture_hw_start_i,
  input  wire                                  capture_hw_stop_i,
  input  wire                                  capture_sw_reset_i,
  input  wire                                  readout_sw_reset_i,
  input  wire                                  readout_start_i,
  output wire                                  capture_full_o,
  output wire [CHANNELS*DW-1:0]                write_depth_o,
  output wire                                  write_depth_valid_o,
  output wire [DATA_WIDTH-1:0]                 readout_data_o,
  output wire                                  readout_valid_o,
  output wire                                  readout_last_o
);

  sample_buffer_pkg::buffer_state_e state;
  logic [sample_buffer_pkg::MODE_W-1:0] banking_mode;
  logic depth_report;
  logic banks_full;
  logic readout_done;
  logic [CHANNELS-1:0] write_en;
  logic [CHANNELS*AW-1:0] write_addr;
  logic [BANK_W-1:0] read_bank;
  logic [AW-1:0] read_addr;

  capture_fsm fsm0 (
    .ps_clk             (ps_clk),
    .rst_n_i            (rst_n_i),
    .capture_arm_i      (capture_arm_i),
    .banking_mode_i     (banking_mode_i),
    .capture_hw_start_i (capture_hw_start_i),
    .capture_hw_stop_i  (capture_hw_stop_i),
    .capture_sw_reset_i (capture_sw_reset_i),
    .readout_sw_reset_i (readout_sw_reset_i),
    .readout_start_i    (readout_start_i),
    .banks_full_i       (banks_full),
    .readout_done_i     (readout_done),
    .state_o            (state),
    .banking_mode_o     (banking_mode),
    .depth_report_o     (depth_report)
  );

  sample_counter #(
    .CHANNELS     (CHANNELS),
    .BUFFER_DEPTH (BUFFER_DEPTH)
  ) counter0 (
    .ps_clk              (ps_clk),
    .rst_n_i             (rst_n_i),
    .state_i             (state),
    .banking_mode_i      (banking_mode),
    .adc_valid_i         (adc_valid_i),
    .depth_report_i      (depth_report),
    .write_en_o          (write_en),
    .write_addr_o        (write_addr),
    .banks_full_o        (banks_full),
    .capture_full_o      (capture_full_o),
    .write_depth_o       (write_depth_o),
    .write_depth_valid_o (write_depth_valid_o)
  );

  bank_memory #(
    .CHANNELS     (CHANNELS),
    .DATA_WIDTH   (DATA_WIDTH),
    .BUFFER_DEPTH (BUFFER_DEPTH),
    .READ_LATENCY (READ_LATENCY)
  ) mem0 (
    .ps_clk         (ps_clk),
    .adc_data_i     (adc_data_i),
    .banking_mode_i (banking_mode),
    .write_en_i     (write_en),
    .write_addr_i   (write_addr),
    .read_bank_i    (read_bank),
    .read_addr_i    (read_addr),
    .read_data_o    (readout_data_o)
  );

  // reads its bank depths from the registered depth word
  readout_sequencer #(
    .CHANNELS     (CHANNELS),
    .BUFFER_DEPTH (BUFFER_DEPTH),
    .READ_LATENCY (READ_LATENCY)
  ) seq0 (
    .ps_clk          (ps_clk),
    .rst_n_i         (rst_n_i),
    .state_i         (state),
    .write_depth_i   (write_depth_o),
    .read_bank_o     (read_bank),
    .read_addr_o     (read_addr),
    .readout_valid_o (readout_valid_o),
    .readout_last_o  (readout_last_o),
    .readout_done_o  (readout_done)
  );

endmodule

`default_nettype wire

// File: sample_buffer_assertions.sv
`default_nettype none

module sample_buffer_assertions (
  input wire                               ps_clk,
  input wire                               rst_n_i,
  input sample_buffer_pkg::buffer_state_e  state_i,
  input wire                               readout_valid_i,
  input wire                               readout_last_i,
  input wire                               write_depth_valid_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // valid only in readout or in the drain cycle right after it
  assert property (@(posedge ps_clk) disable iff (!rst_n_i)
    readout_valid_i |-> ((state_i == sample_buffer_pkg::READOUT) ||
                         ($past(state_i) == sample_buffer_pkg::READOUT)))
    else $error("readout valid outside readout");

  // one depth pulse per capture
  assert property (@(posedge ps_clk) disable iff (!rst_n_i)
    write_depth_valid_i |=> !write_depth_valid_i)
    else $error("write depth valid longer than one cycle");

  assert property (@(posedge ps_clk) disable iff (!rst_n_i)
    readout_last_i |-> readout_valid_i)
    else $error("readout last without readout valid");

endmodule

bind sample_buffer sample_buffer_assertions sva0 (
  .ps_clk              (ps_clk),
  .rst_n_i             (rst_n_i),
  .state_i             (state),
  .readout_valid_i     (readout_valid_o),
  .readout_last_i      (readout_last_o),
  .write_depth_valid_i (write_depth_valid_o)
);

`default_nettype wire

// File: sample_buffer_pkg.sv
`default_nettype none

package sample_buffer_pkg;

  // capture and readout states, shared by the fsm and the datapath blocks
  typedef enum logic [2:0] {
    IDLE    = 3'd0,
    // waiting for the hardware start trigger
    ARMED   = 3'd1,
    // samples are written while the strobe is high
    CAPTURE = 3'd2,
    // data and depths held until a readout starts
    HOLD    = 3'd3,
    // stored words are played back one per cycle
    READOUT = 3'd4
  } buffer_state_e;

  // banking mode field
  // 0 means one bank per channel, 1 means channel 0 chains through all banks
  localparam int MODE_W = 1;

  // defaults picked up by the top level
  localparam int DEFAULT_CHANNELS = 2;
  localparam int DEFAULT_DATA_WIDTH = 16;
  // words per bank
  localparam int DEFAULT_BUFFER_DEPTH = 64;
  // register stages between read address and read data
  localparam int DEFAULT_READ_LATENCY = 3;

endpackage

`default_nettype wire

// File: sample_buffer_tb.sv
`default_nettype none

module sample_buffer_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CH = sample_buffer_pkg::DEFAULT_CHANNELS;
  localparam int DWID = sample_buffer_pkg::DEFAULT_DATA_WIDTH;
  localparam int DEPTH = sample_buffer_pkg::DEFAULT_BUFFER_DEPTH;
  localparam int LAT = sample_buffer_pkg::DEFAULT_READ_LATENCY;
  localparam int DW = $clog2(DEPTH) + 1;
  localparam int PERIOD = 4;
  localparam int WAIT_LIMIT = 400;
  // ways a capture run can end
  localparam int END_STOP = 0;
  localparam int END_FULL = 1;
  localparam int END_RESET = 2;

  logic ps_clk;
  logic rst_n_i;
  logic [CH*DWID-1:0] adc_data_i;
  logic adc_valid_i;
  logic capture_arm_i;
  logic [sample_buffer_pkg::MODE_W-1:0] banking_mode_i;
  logic capture_hw_start_i;
  logic capture_hw_stop_i;
  logic capture_sw_reset_i;
  logic readout_sw_reset_i;
  logic readout_start_i;
  wire capture_full_o;
  wire [CH*DW-1:0] write_depth_o;
  wire write_depth_valid_o;
  wire [DWID-1:0] readout_data_o;
  wire readout_valid_o;
  wire readout_last_o;

  // reference model with one array of expected words per bank
  logic [DWID-1:0] exp_mem [CH][DEPTH];
  int exp_cnt [CH];
  // what the monitor saw
  logic [DWID-1:0] got_data [$];
  bit got_last [$];
  time got_time [$];
  logic [CH*DW-1:0] depth_seen [$];
  int last_count;
  logic [31:0] rng_state;
  int errors;
  int tests_run;
  int tests_failed;
  int errs0;

  sample_buffer #(
    .CHANNELS     (CH),
    .DATA_WIDTH   (DWID),
    .BUFFER_DEPTH (DEPTH),
    .READ_LATENCY (LAT)
  ) dut0 (
    .ps_clk              (ps_clk),
    .rst_n_i             (rst_n_i),
    .adc_data_i          (adc_data_i),
    .adc_valid_i         (adc_valid_i),
    .capture_arm_i       (capture_arm_i),
    .banking_mode_i      (banking_mode_i),
    .capture_hw_start_i  (capture_hw_start_i),
    .capture_hw_stop_i   (capture_hw_stop_i),
    .capture_sw_reset_i  (capture_sw_reset_i),
    .readout_sw_reset_i  (readout_sw_reset_i),
    .readout_start_i     (readout_start_i),
    .capture_full_o      (capture_full_o),
    .write_depth_o       (write_depth_o),
    .write_depth_valid_o (write_depth_valid_o),
    .readout_data_o      (readout_data_o),
    .readout_valid_o     (readout_valid_o),
    .readout_last_o      (readout_last_o)
  );

  always #(PERIOD / 2) ps_clk = ~ps_clk;

  // outputs are sampled mid-cycle where they are settled
  always @(negedge ps_clk) begin
    if (rst_n_i) begin
      if (readout_valid_o) begin
        got_data.push_back(readout_data_o);
        got_last.push_back(readout_last_o);
        got_time.push_back($time);
        if (readout_last_o) begin
          last_count++;
        end
      end
      if (write_depth_valid_o) begin
        depth_seen.push_back(write_depth_o);
      end
    end
  end

  // xorshift32
  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic logic [CH*DWID-1:0] rand_word();
    logic [63:0] r;
    r = {next_rand(), next_rand()};
    return r[CH*DWID-1:0];
  endfunction

  function automatic logic [CH*DW-1:0] expected_depth();
    logic [CH*DW-1:0] w;
    w = '0;
    for (int b = 0; b < CH; b++) begin
      w[b*DW +: DW] = DW'(exp_cnt[b]);
    end
    return w;
  endfunction

  function automatic int expected_total();
    int n;
    n = 0;
    for (int b = 0; b < CH; b++) begin
      n += exp_cnt[b];
    end
    return n;
  endfunction

  // banks come out in index order and empty banks contribute nothing
  function automatic logic [DWID-1:0] expected_at(input int idx);
    int rest;
    rest = idx;
    for (int b = 0; b < CH; b++) begin
      if (rest < exp_cnt[b]) begin
        return exp_mem[b][rest];
      end
      rest -= exp_cnt[b];
    end
    return 'x;
  endfunction

  task automatic model_write(input int mode, input logic [CH*DWID-1:0] word);
    bit placed;
    placed = 1'b0;
    for (int b = 0; b < CH; b++) begin
      if (mode == 0 && exp_cnt[b] < DEPTH) begin
        exp_mem[b][exp_cnt[b]] = word[b*DWID +: DWID];
        exp_cnt[b]++;
      end else if (mode != 0 && !placed && exp_cnt[b] < DEPTH) begin
        // in chained mode channel 0 lands in the first bank with room
        exp_mem[b][exp_cnt[b]] = word[DWID-1:0];
        exp_cnt[b]++;
        placed = 1'b1;
      end
    end
  endtask

  task automatic report_error(input string msg);
    $display("FAILED at %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic clear_monitors();
    got_data.delete();
    got_last.delete();
    got_time.delete();
    depth_seen.delete();
    last_count = 0;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors > errs0) begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - errs0);
    end else begin
      $display("test %s: ok", name);
    end
    errs0 = errors;
  endtask

  // fixed window in which nothing may come out
  task automatic quiet_window(input int n, input string what);
    repeat (n) @(posedge ps_clk);
    if (depth_seen.size() != 0) begin
      report_error($sformatf("%s: unexpected depth pulse", what));
    end
    if (got_data.size() != 0) begin
      report_error($sformatf("%s: unexpected readout valid", what));
    end
  endtask

  // arm, start, then stream samples; the sample in the start cycle is dropped
  task automatic run_capture(input int mode, input int n, input int end_kind, input bit dense);
    logic [CH*DWID-1:0] word;
    bit v;
    for (int b = 0; b < CH; b++) begin
      exp_cnt[b] = 0;
    end
    @(posedge ps_clk);
    capture_arm_i <= 1'b1;
    banking_mode_i <= sample_buffer_pkg::MODE_W'(mode);
    @(posedge ps_clk);
    capture_arm_i <= 1'b0;
    capture_hw_start_i <= 1'b1;
    adc_data_i <= rand_word();
    adc_valid_i <= 1'b1;
    for (int i = 0; i < n; i++) begin
      @(posedge ps_clk);
      capture_hw_start_i <= 1'b0;
      word = rand_word();
      v = dense || ((next_rand() & 32'h3) != 0);
      adc_data_i <= word;
      adc_valid_i <= v;
      if (v) begin
        model_write(mode, word);
      end
      if (i == n - 1 && end_kind != END_FULL) begin
        // stop with the reset as well, so the reset must win
        capture_hw_stop_i <= 1'b1;
        capture_sw_reset_i <= (end_kind == END_RESET);
      end
    end
    @(posedge ps_clk);
    adc_valid_i <= 1'b0;
    capture_hw_stop_i <= 1'b0;
    capture_sw_reset_i <= 1'b0;
  endtask

  task automatic check_depth(input bit exp_full);
    int n;
    n = 0;
    while (depth_seen.size() == 0 && n < WAIT_LIMIT) begin
      @(posedge ps_clk);
      n++;
    end
    if (depth_seen.size() == 0) begin
      $display("timeout while waiting for the write depth pulse");
      errors++;
    end else if (depth_seen[0] !== expected_depth()) begin
      report_error($sformatf("depth word %h, expected %h", depth_seen[0], expected_depth()));
    end
    repeat (3) @(posedge ps_clk);
    @(negedge ps_clk);
    if (depth_seen.size() > 1) begin
      report_error($sformatf("%0d depth pulses for one capture", depth_seen.size()));
    end
    if (capture_full_o !== exp_full) begin
      report_error($sformatf("capture_full_o is %b in hold, expected %b", capture_full_o, exp_full));
    end
  endtask

  task automatic readout_and_check();
    time t_start;
    int n;
    int total;
    total = expected_total();
    clear_monitors();
    @(posedge ps_clk);
    readout_start_i <= 1'b1;
    t_start = $time;
    @(posedge ps_clk);
    readout_start_i <= 1'b0;
    if (total == 0) begin
      quiet_window(12, "empty readout");
    end else begin
      n = 0;
      while (last_count == 0 && n < WAIT_LIMIT) begin
        @(posedge ps_clk);
        n++;
      end
      if (last_count == 0) begin
        $display("timeout while waiting for the last readout word");
        errors++;
      end
      // extra words after last would show up here
      repeat (2) @(posedge ps_clk);
    end
    if (got_data.size() != total) begin
      report_error($sformatf("readout gave %0d words, expected %0d", got_data.size(), total));
    end
    for (int i = 0; i < got_data.size() && i < total; i++) begin
      if (got_data[i] !== expected_at(i)) begin
        report_error($sformatf("word %0d is %h, expected %h", i, got_data[i], expected_at(i)));
      end
      if (got_last[i] != (i == total - 1)) begin
        report_error($sformatf("last marker is %b on word %0d of %0d", got_last[i], i, total));
      end
      if (i == 0 && got_time[0] != t_start + (LAT + 1) * PERIOD + PERIOD / 2) begin
        report_error($sformatf("first word at %0t, start at %0t", got_time[0], t_start));
      end
      if (i > 0 && got_time[i] != got_time[i-1] + PERIOD) begin
        report_error($sformatf("gap before word %0d", i));
      end
    end
  endtask

  initial begin
    ps_clk = 1'b0;
    rst_n_i = 1'b0;
    adc_data_i = '0;
    adc_valid_i = 1'b0;
    capture_arm_i = 1'b0;
    banking_mode_i = '0;
    capture_hw_start_i = 1'b0;
    capture_hw_stop_i = 1'b0;
    capture_sw_reset_i = 1'b0;
    readout_sw_reset_i = 1'b0;
    readout_start_i = 1'b0;
    rng_state = 32'd84;
    errors = 0;
    errs0 = 0;
    tests_run = 0;
    tests_failed = 0;
    clear_monitors();
    repeat (5) @(posedge ps_clk);
    rst_n_i <= 1'b1;
    @(negedge ps_clk);
    if (write_depth_valid_o || readout_valid_o || readout_last_o || capture_full_o) begin
      report_error("outputs not low after reset");
    end
    finish_test("reset values");

    // random captures ended by a hardware stop
    for (int mode = 0; mode < 2; mode++) begin
      for (int rep = 0; rep < 2; rep++) begin
        clear_monitors();
        run_capture(mode, 5 + int'(next_rand() % 30), END_STOP, 1'b0);
        check_depth(1'b0);
        readout_and_check();
      end
    end
    finish_test("stop capture");

    // captures that run until every bank is full
    for (int mode = 0; mode < 2; mode++) begin
      clear_monitors();
      run_capture(mode, (mode == 0 ? DEPTH : CH * DEPTH) + 4, END_FULL, 1'b1);
      check_depth(1'b1);
      for (int b = 0; b < CH; b++) begin
        if (write_depth_o[b*DW +: DW] !== DW'(DEPTH)) begin
          report_error($sformatf("bank %0d depth is %0d, expected %0d", b,
                                 write_depth_o[b*DW +: DW], DEPTH));
        end
      end
      readout_and_check();
      @(negedge ps_clk);
      if (capture_full_o) begin
        report_error("capture_full_o still high after readout");
      end
    end
    finish_test("full capture");

    // triggers out of order are ignored
    clear_monitors();
    @(posedge ps_clk);
    capture_hw_start_i <= 1'b1;
    adc_valid_i <= 1'b1;
    adc_data_i <= rand_word();
    @(posedge ps_clk);
    capture_hw_start_i <= 1'b0;
    capture_hw_stop_i <= 1'b1;
    @(posedge ps_clk);
    capture_hw_stop_i <= 1'b0;
    adc_valid_i <= 1'b0;
    readout_start_i <= 1'b1;
    @(posedge ps_clk);
    readout_start_i <= 1'b0;
    quiet_window(20, "start without arm");
    finish_test("ignored triggers");

    // capture reset from armed
    clear_monitors();
    @(posedge ps_clk);
    capture_arm_i <= 1'b1;
    @(posedge ps_clk);
    capture_arm_i <= 1'b0;
    repeat (1 + int'(next_rand() % 5)) @(posedge ps_clk);
    capture_sw_reset_i <= 1'b1;
    @(posedge ps_clk);
    capture_sw_reset_i <= 1'b0;
    // back in idle, so this start and stop must not capture anything
    capture_hw_start_i <= 1'b1;
    @(posedge ps_clk);
    capture_hw_start_i <= 1'b0;
    capture_hw_stop_i <= 1'b1;
    @(posedge ps_clk);
    capture_hw_stop_i <= 1'b0;
    quiet_window(10, "reset in armed");
    // capture reset from capture together with a stop
    clear_monitors();
    run_capture(int'(next_rand() % 2), 1 + int'(next_rand() % 10), END_RESET, 1'b0);
    quiet_window(15, "reset in capture");
    // capture reset from hold must drop the data
    clear_monitors();
    run_capture(0, 10, END_STOP, 1'b1);
    check_depth(1'b0);
    clear_monitors();
    @(posedge ps_clk);
    capture_sw_reset_i <= 1'b1;
    @(posedge ps_clk);
    capture_sw_reset_i <= 1'b0;
    readout_start_i <= 1'b1;
    @(posedge ps_clk);
    readout_start_i <= 1'b0;
    quiet_window(15, "reset in hold");
    if (write_depth_o !== '0) begin
      report_error($sformatf("depth word %h not cleared by capture reset", write_depth_o));
    end
    clear_monitors();
    run_capture(1, 5 + int'(next_rand() % 30), END_STOP, 1'b0);
    check_depth(1'b0);
    readout_and_check();
    finish_test("capture reset");

    // readout reset in the middle of a readout
    clear_monitors();
    run_capture(0, 24, END_STOP, 1'b1);
    check_depth(1'b0);
    clear_monitors();
    @(posedge ps_clk);
    readout_start_i <= 1'b1;
    @(posedge ps_clk);
    readout_start_i <= 1'b0;
    repeat (3 + int'(next_rand() % 10)) @(posedge ps_clk);
    readout_sw_reset_i <= 1'b1;
    @(posedge ps_clk);
    readout_sw_reset_i <= 1'b0;
    // words before the reset are a prefix of the full order
    for (int i = 0; i < got_data.size(); i++) begin
      if (got_data[i] !== expected_at(i) || got_last[i]) begin
        report_error($sformatf("aborted readout word %0d is %h", i, got_data[i]));
      end
    end
    clear_monitors();
    quiet_window(8, "after readout reset");
    readout_and_check();
    finish_test("readout reset");

    $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sample_counter.sv
`default_nettype none

module sample_counter #(
  parameter int CHANNELS = 2,
  parameter int BUFFER_DEPTH = 64,
  localparam int AW = $clog2(BUFFER_DEPTH),
  localparam int DW = AW + 1
) (
  input  wire                                     ps_clk,
  input  wire                                     rst_n_i,
  input  sample_buffer_pkg::buffer_state_e        state_i,
  input  wire [sample_buffer_pkg::MODE_W-1:0]     banking_mode_i,
  input  wire                                     adc_valid_i,
  input  wire                                     depth_report_i,
  output logic [CHANNELS-1:0]                     write_en_o,
  output logic [CHANNELS*AW-1:0]                  write_addr_o,
  output logic                                    banks_full_o,
  output logic                                    capture_full_o,
  output logic [CHANNELS*DW-1:0]                  write_depth_o,
  output logic                                    write_depth_valid_o
);

  localparam logic [DW-1:0] FULL_CNT = DW'(BUFFER_DEPTH);

  // one count per bank, doubles as the write address
  logic [DW-1:0] cnt_q [CHANNELS];
  logic [DW-1:0] cnt_next [CHANNELS];
  logic capture_wr;

  assign capture_wr = (state_i == sample_buffer_pkg::CAPTURE) && adc_valid_i;

  always_comb begin
    logic lower_full;
    lower_full = 1'b1;
    banks_full_o = 1'b1;
    for (int b = 0; b < CHANNELS; b++) begin
      if (banking_mode_i == '0) begin
        // every channel writes its own bank in lockstep
        write_en_o[b] = capture_wr && (cnt_q[b] != FULL_CNT);
      end else begin
        // chained: a bank takes samples once all lower banks are full
        write_en_o[b] = capture_wr && (cnt_q[b] != FULL_CNT) && lower_full;
      end
      lower_full = lower_full && (cnt_q[b] == FULL_CNT);
      cnt_next[b] = cnt_q[b] + DW'(write_en_o[b]);
      write_addr_o[b*AW +: AW] = cnt_q[b][AW-1:0];
      // both modes use every bank, so full means all banks at depth
      // looks at the next count so it rises with the last write
      banks_full_o = banks_full_o && (cnt_next[b] == FULL_CNT);
    end
  end

  // counts are frozen in hold and readout, so the flag stays up there
  assign capture_full_o = banks_full_o &&
                          ((state_i == sample_buffer_pkg::HOLD) ||
                           (state_i == sample_buffer_pkg::READOUT));

  always_ff @(posedge ps_clk) begin
    if (!rst_n_i) begin
      for (int b = 0; b < CHANNELS; b++) begin
        cnt_q[b] <= '0;
      end
      write_depth_o <= '0;
      write_depth_valid_o <= 1'b0;
    end else begin
      for (int b = 0; b < CHANNELS; b++) begin
        // idle covers the capture reset, armed covers a fresh arm
        if ((state_i == sample_buffer_pkg::IDLE) || (state_i == sample_buffer_pkg::ARMED)) begin
          cnt_q[b] <= '0;
        end else begin
          cnt_q[b] <= cnt_next[b];
        end
      end
      write_depth_valid_o <= depth_report_i;
      if (depth_report_i) begin
        // include a write that lands in the stop cycle
        for (int b = 0; b < CHANNELS; b++) begin
          write_depth_o[b*DW +: DW] <= cnt_next[b];
        end
      end else if (state_i == sample_buffer_pkg::IDLE) begin
        write_depth_o <= '0;
      end
    end
  end

endmodule

`default_nettype wire
